//--- include/core_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core widths for the memory-access path
// data RAM depth and access latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and bus widths
`define XLEN         64
`define ADDR_W       64
`define REG_ADDR_W   5
`define INST_W       32

// doublewords held by the data RAM
`define DRAM_WORDS   512
// cycles from an accepted request to the finish pulse
`define DRAM_LATENCY 2

`endif

//--- source/lsu_op_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store select codes (funct3)
// store aliases and instruction-type bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lsu_op_pkg;

    // width of the one-hot-ish instruction type vector
    localparam int INST_TYPE_W = 8;

    // bit positions inside the instruction type vector
    localparam int INST_STORE_BIT = 0;
    localparam int INST_LOAD_BIT  = 1;

    // funct3 of the load instructions
    typedef enum logic [2:0] {
        LS_LB  = 3'd0,
        LS_LH  = 3'd1,
        LS_LW  = 3'd2,
        LS_LD  = 3'd3,
        LS_LBU = 3'd4,
        LS_LHU = 3'd5,
        LS_LWU = 3'd6
    } ls_sel_e;

    // stores reuse the low four codes of the same field
    localparam ls_sel_e SEL_SB = LS_LB;
    localparam ls_sel_e SEL_SH = LS_LH;
    localparam ls_sel_e SEL_SW = LS_LW;
    localparam ls_sel_e SEL_SD = LS_LD;

endpackage

//--- source/dbus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data bus access-size codes
// lane view of one 64-bit data word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

package dbus_pkg;

    // size of a RAM access, 3'b111 means no access
    typedef enum logic [2:0] {
        SIZE_BYTE   = 3'b000,
        SIZE_HALF   = 3'b001,
        SIZE_WORD   = 3'b010,
        SIZE_DOUBLE = 3'b100,
        SIZE_NONE   = 3'b111
    } access_size_e;

    // one doubleword seen as bytes, halves, words or whole
    // lane 0 is the least significant in every view
    typedef union packed {
        logic [`XLEN/8-1:0][7:0]   b;
        logic [`XLEN/16-1:0][15:0] h;
        logic [`XLEN/32-1:0][31:0] w;
        logic [`XLEN-1:0]          d;
    } dword_lanes_u;

endpackage

//--- source/mem_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory-access stage
// store lane placement and byte mask, load extraction
// access-size codes and stall level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "core_params.svh"

module mem_stage (
    input  logic                                rst_i,
    input  logic [lsu_op_pkg::INST_TYPE_W-1:0]  inst_type_i,
    input  logic                                rd_ena_i,
    input  logic [`XLEN-1:0]                    op2_i,
    input  logic [`REG_ADDR_W-1:0]              rd_addr_i,
    input  logic [`XLEN-1:0]                    pc_i,
    input  logic [`INST_W-1:0]                  inst_i,
    input  logic [`ADDR_W-1:0]                  ls_addr_i,
    input  lsu_op_pkg::ls_sel_e                 ls_sel_i,

    input  logic [`XLEN-1:0]                    ram_rdata_i,
    input  logic                                ram_finish_i,
    output logic [`ADDR_W-1:0]                  ram_addr_o,
    output logic [`XLEN-1:0]                    ram_wdata_o,
    output logic [7:0]                          ram_wmask_o,
    output logic                                ram_we_o,
    output logic                                ram_re_o,
    output dbus_pkg::access_size_e              ram_wsize_o,
    output dbus_pkg::access_size_e              ram_rsize_o,

    output logic                                rd_ena_o,
    output logic [`REG_ADDR_W-1:0]              rd_addr_o,
    output logic [`XLEN-1:0]                    rd_data_o,
    output logic [`XLEN-1:0]                    pc_o,
    output logic [`INST_W-1:0]                  inst_o,
    output logic                                stall_o
);

    logic [2:0]             byte_sel;
    logic [1:0]             half_sel;
    logic                   word_sel;

    dbus_pkg::dword_lanes_u st_lanes;
    logic [7:0]             st_mask;
    dbus_pkg::access_size_e st_size;

    dbus_pkg::dword_lanes_u ld_lanes;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [31:0]            ld_word;
    logic [`XLEN-1:0]       ld_data;
    dbus_pkg::access_size_e ld_size;

    // lane selects from the low address bits
    assign byte_sel = ls_addr_i[2:0];
    assign half_sel = ls_addr_i[2:1];
    assign word_sel = ls_addr_i[2];

    // strobes straight from the instruction type, quiet in reset
    assign ram_we_o = !rst_i && inst_type_i[lsu_op_pkg::INST_STORE_BIT];
    assign ram_re_o = !rst_i && inst_type_i[lsu_op_pkg::INST_LOAD_BIT];

    // store: drop the operand into its lanes and mark those bytes
    always_comb begin
        st_lanes.d = '0;
        st_mask    = '0;
        st_size    = dbus_pkg::SIZE_NONE;
        case (ls_sel_i)
            lsu_op_pkg::SEL_SB: begin
                st_lanes.b[byte_sel] = op2_i[7:0];
                st_mask              = 8'b0000_0001 << byte_sel;
                st_size              = dbus_pkg::SIZE_BYTE;
            end
            lsu_op_pkg::SEL_SH: begin
                st_lanes.h[half_sel] = op2_i[15:0];
                st_mask              = 8'b0000_0011 << {half_sel, 1'b0};
                st_size              = dbus_pkg::SIZE_HALF;
            end
            lsu_op_pkg::SEL_SW: begin
                st_lanes.w[word_sel] = op2_i[31:0];
                st_mask              = 8'b0000_1111 << {word_sel, 2'b00};
                st_size              = dbus_pkg::SIZE_WORD;
            end
            lsu_op_pkg::SEL_SD: begin
                st_lanes.d = op2_i;
                st_mask    = 8'hff;
                st_size    = dbus_pkg::SIZE_DOUBLE;
            end
            default: ;
        endcase
    end

    assign ram_addr_o  = ls_addr_i;
    assign ram_wdata_o = ram_we_o ? st_lanes.d : '0;
    assign ram_wmask_o = ram_we_o ? st_mask : '0;
    assign ram_wsize_o = ram_we_o ? st_size : dbus_pkg::SIZE_NONE;

    // load: pick the addressed lane out of the returned word
    assign ld_lanes = ram_rdata_i;
    assign ld_byte  = ld_lanes.b[byte_sel];
    assign ld_half  = ld_lanes.h[half_sel];
    assign ld_word  = ld_lanes.w[word_sel];

    always_comb begin
        ld_data = '0;
        ld_size = dbus_pkg::SIZE_NONE;
        case (ls_sel_i)
            lsu_op_pkg::LS_LB: begin
                ld_data = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
                ld_size = dbus_pkg::SIZE_BYTE;
            end
            lsu_op_pkg::LS_LH: begin
                ld_data = {{(`XLEN-16){ld_half[15]}}, ld_half};
                ld_size = dbus_pkg::SIZE_HALF;
            end
            lsu_op_pkg::LS_LW: begin
                ld_data = {{(`XLEN-32){ld_word[31]}}, ld_word};
                ld_size = dbus_pkg::SIZE_WORD;
            end
            lsu_op_pkg::LS_LD: begin
                ld_data = ld_lanes.d;
                ld_size = dbus_pkg::SIZE_DOUBLE;
            end
            lsu_op_pkg::LS_LBU: begin
                ld_data = {{(`XLEN-8){1'b0}}, ld_byte};
                ld_size = dbus_pkg::SIZE_BYTE;
            end
            lsu_op_pkg::LS_LHU: begin
                ld_data = {{(`XLEN-16){1'b0}}, ld_half};
                ld_size = dbus_pkg::SIZE_HALF;
            end
            lsu_op_pkg::LS_LWU: begin
                ld_data = {{(`XLEN-32){1'b0}}, ld_word};
                ld_size = dbus_pkg::SIZE_WORD;
            end
            default: ;
        endcase
    end

    assign ram_rsize_o = ram_re_o ? ld_size : dbus_pkg::SIZE_NONE;

    // only loads produce a result on this path
    assign rd_data_o = ram_re_o ? ld_data : '0;
    assign rd_ena_o  = rd_ena_i;
    assign rd_addr_o = rd_addr_i;
    assign pc_o      = pc_i;
    assign inst_o    = inst_i;

    // hold upstream until the RAM reports completion
    assign stall_o = (ram_re_o || ram_we_o) && !ram_finish_i;

    // a store always writes some bytes and nothing else does
    // upstream must never flag an instruction as both load and store
    always_comb begin
        if (!rst_i) begin
            assert (ram_we_o == (ram_wmask_o != '0))
                else $error("mem_stage: write strobe %b with write mask %h",
                            ram_we_o, ram_wmask_o);
            assert (!(ram_re_o && ram_we_o))
                else $error("mem_stage: load and store strobes high together");
        end
    end

endmodule

//--- source/data_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-masked doubleword data RAM
// fixed latency with a one-cycle finish pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "core_params.svh"

module data_ram (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`ADDR_W-1:0]     addr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`XLEN/8-1:0]     wmask_i,
    input  logic                   we_i,
    input  logic                   re_i,
    input  dbus_pkg::access_size_e wsize_i,
    input  dbus_pkg::access_size_e rsize_i,
    output logic [`XLEN-1:0]       rdata_o,
    output logic                   finish_o
);

    localparam int IDX_W = $clog2(`DRAM_WORDS);
    localparam int CNT_W = $clog2(`DRAM_LATENCY + 1);

    dbus_pkg::dword_lanes_u mem [`DRAM_WORDS];
    dbus_pkg::dword_lanes_u wr_lanes;
    logic [IDX_W-1:0]       idx;
    logic [`XLEN-1:0]       rdata_q;
    logic                   busy_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   accept;
    logic [3:0]             wsize_bytes;

    // doubleword index sits above the byte offset
    assign idx      = addr_i[IDX_W+2:3];
    assign wr_lanes = wdata_i;
    assign accept   = !busy_q && (re_i || we_i);
    assign finish_o = busy_q && (cnt_q == '0);
    assign rdata_o  = rdata_q;

    // countdown from acceptance to the finish cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(`DRAM_LATENCY - 1);
        end else if (finish_o) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // read every cycle, write only the masked bytes when finishing
    always_ff @(posedge clk) begin
        rdata_q <= mem[idx].d;
        if (finish_o && we_i) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (wmask_i[i]) begin
                    mem[idx].b[i] <= wr_lanes.b[i];
                end
            end
        end
    end

    always_comb begin
        case (wsize_i)
            dbus_pkg::SIZE_BYTE:   wsize_bytes = 4'd1;
            dbus_pkg::SIZE_HALF:   wsize_bytes = 4'd2;
            dbus_pkg::SIZE_WORD:   wsize_bytes = 4'd4;
            dbus_pkg::SIZE_DOUBLE: wsize_bytes = 4'd8;
            default:               wsize_bytes = 4'd0;
        endcase
    end

    // finish comes exactly the latency after acceptance, then idle
    a_finish_time: assert property (@(posedge clk) disable iff (rst_i)
        accept |-> ##(`DRAM_LATENCY) (finish_o ##1 !busy_q))
        else $error("data_ram: finish not %0d cycles after request", `DRAM_LATENCY);

    // the stage must hold its request for the whole access
    a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
        busy_q |-> ($stable(addr_i) && $stable(we_i) && $stable(re_i)
                    && $stable(wmask_i) && $stable(wdata_i)))
        else $error("data_ram: request changed while busy");

    a_size_match: assert property (@(posedge clk) disable iff (rst_i)
        (!we_i || ($countones(wmask_i) == wsize_bytes))
        && (!re_i || (rsize_i != dbus_pkg::SIZE_NONE)))
        else $error("data_ram: mask %h does not fit size %b", wmask_i, wsize_i);

endmodule

//--- source/mem_wb_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM/WB pipeline register
// holds its contents while the stage stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "core_params.svh"

module mem_wb_reg (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   stall_i,

    input  logic                   rd_ena_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`XLEN-1:0]       rd_data_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`INST_W-1:0]     inst_i,

    output logic                   rd_ena_o,
    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    output logic [`XLEN-1:0]       rd_data_o,
    output logic [`XLEN-1:0]       pc_o,
    output logic [`INST_W-1:0]     inst_o
);

    // writeback sees zeros until the first instruction lands
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_ena_o  <= 1'b0;
            rd_addr_o <= '0;
            rd_data_o <= '0;
            pc_o      <= '0;
            inst_o    <= '0;
        end else if (!stall_i) begin
            rd_ena_o  <= rd_ena_i;
            rd_addr_o <= rd_addr_i;
            rd_data_o <= rd_data_i;
            pc_o      <= pc_i;
            inst_o    <= inst_i;
        end
    end

    // a stalled cycle leaves writeback untouched
    a_hold: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable({rd_ena_o, rd_addr_o, rd_data_o, pc_o, inst_o}))
        else $error("mem_wb_reg: writeback changed after a stalled cycle");

endmodule

//--- source/mem_subsys_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem top level
// stage, data RAM and writeback register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "core_params.svh"

module mem_subsys_top (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [lsu_op_pkg::INST_TYPE_W-1:0] inst_type_i,
    input  logic                               rd_ena_i,
    input  logic [`XLEN-1:0]                   op2_i,
    input  logic [`REG_ADDR_W-1:0]             rd_addr_i,
    input  logic [`XLEN-1:0]                   pc_i,
    input  logic [`INST_W-1:0]                 inst_i,
    input  logic [`ADDR_W-1:0]                 ls_addr_i,
    input  lsu_op_pkg::ls_sel_e                ls_sel_i,

    output logic                               wb_rd_ena_o,
    output logic [`REG_ADDR_W-1:0]             wb_rd_addr_o,
    output logic [`XLEN-1:0]                   wb_rd_data_o,
    output logic [`XLEN-1:0]                   wb_pc_o,
    output logic [`INST_W-1:0]                 wb_inst_o,
    output logic                               stall_o
);

    // stage to RAM
    logic [`ADDR_W-1:0]     ram_addr;
    logic [`XLEN-1:0]       ram_wdata;
    logic [`XLEN/8-1:0]     ram_wmask;
    logic                   ram_we;
    logic                   ram_re;
    dbus_pkg::access_size_e ram_wsize;
    dbus_pkg::access_size_e ram_rsize;
    logic [`XLEN-1:0]       ram_rdata;
    logic                   ram_finish;

    // stage to writeback register
    logic                   mem_rd_ena;
    logic [`REG_ADDR_W-1:0] mem_rd_addr;
    logic [`XLEN-1:0]       mem_rd_data;
    logic [`XLEN-1:0]       mem_pc;
    logic [`INST_W-1:0]     mem_inst;

    mem_stage u_mem_stage (
        .rst_i       (rst_i),
        .inst_type_i (inst_type_i),
        .rd_ena_i    (rd_ena_i),
        .op2_i       (op2_i),
        .rd_addr_i   (rd_addr_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .ls_addr_i   (ls_addr_i),
        .ls_sel_i    (ls_sel_i),
        .ram_rdata_i (ram_rdata),
        .ram_finish_i(ram_finish),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_wmask_o (ram_wmask),
        .ram_we_o    (ram_we),
        .ram_re_o    (ram_re),
        .ram_wsize_o (ram_wsize),
        .ram_rsize_o (ram_rsize),
        .rd_ena_o    (mem_rd_ena),
        .rd_addr_o   (mem_rd_addr),
        .rd_data_o   (mem_rd_data),
        .pc_o        (mem_pc),
        .inst_o      (mem_inst),
        .stall_o     (stall_o)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst_i   (rst_i),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .wmask_i (ram_wmask),
        .we_i    (ram_we),
        .re_i    (ram_re),
        .wsize_i (ram_wsize),
        .rsize_i (ram_rsize),
        .rdata_o (ram_rdata),
        .finish_o(ram_finish)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .stall_i  (stall_o),
        .rd_ena_i (mem_rd_ena),
        .rd_addr_i(mem_rd_addr),
        .rd_data_i(mem_rd_data),
        .pc_i     (mem_pc),
        .inst_i   (mem_inst),
        .rd_ena_o (wb_rd_ena_o),
        .rd_addr_o(wb_rd_addr_o),
        .rd_data_o(wb_rd_data_o),
        .pc_o     (wb_pc_o),
        .inst_o   (wb_inst_o)
    );

endmodule

//--- bench/tb_mem_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory subsystem
// reference RAM model, directed and random stimulus
// writeback and stall assertions, timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "core_params.svh"

module tb_mem_subsys;

    localparam int RESET_CYCLES = 10;
    localparam logic [`ADDR_W-1:0] WIN_BASE = 64'h100;
    // init 8, store and read-back 30, loads 29, alu 4, stall mix 6, random 200, tail 1
    localparam int N_PLANNED = 8 + 30 + 29 + 4 + 6 + 200 + 1;
    localparam int CYCLE_LIMIT = 40 * N_PLANNED + RESET_CYCLES;

    logic                   clk;
    logic                   rst_i;
    logic [7:0]             inst_type_i;
    logic                   rd_ena_i;
    logic [`XLEN-1:0]       op2_i;
    logic [`REG_ADDR_W-1:0] rd_addr_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`INST_W-1:0]     inst_i;
    logic [`ADDR_W-1:0]     ls_addr_i;
    lsu_op_pkg::ls_sel_e    ls_sel_i;
    logic                   wb_rd_ena;
    logic [`REG_ADDR_W-1:0] wb_rd_addr;
    logic [`XLEN-1:0]       wb_rd_data;
    logic [`XLEN-1:0]       wb_pc;
    logic [`INST_W-1:0]     wb_inst;
    logic                   stall;

    // expected writeback contents, updated on the edge the register loads
    logic                   exp_rd_ena = 1'b0;
    logic [`REG_ADDR_W-1:0] exp_rd_addr = '0;
    logic [`XLEN-1:0]       exp_rd_data = '0;
    logic [`XLEN-1:0]       exp_pc = '0;
    logic [`INST_W-1:0]     exp_inst = '0;

    logic [`XLEN-1:0]       ref_mem [longint unsigned];
    logic [`XLEN-1:0]       next_pc = 64'h8000_0000;
    int                     seed = 66;
    int                     err_count = 0;
    int                     issued = 0;
    int                     cycles = 0;

    mem_subsys_top dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .inst_type_i (inst_type_i),
        .rd_ena_i    (rd_ena_i),
        .op2_i       (op2_i),
        .rd_addr_i   (rd_addr_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .ls_addr_i   (ls_addr_i),
        .ls_sel_i    (ls_sel_i),
        .wb_rd_ena_o (wb_rd_ena),
        .wb_rd_addr_o(wb_rd_addr),
        .wb_rd_data_o(wb_rd_data),
        .wb_pc_o     (wb_pc),
        .wb_inst_o   (wb_inst),
        .stall_o     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // writeback must match the model every cycle, which also covers holding in a stall
    a_wb_ena: assert property (@(posedge clk) disable iff (rst_i) wb_rd_ena == exp_rd_ena)
        else begin
            $display("CHECK FAILED wb_rd_ena_o got %h expected %h",
                     $sampled(wb_rd_ena), $sampled(exp_rd_ena));
            err_count++;
        end
    a_wb_addr: assert property (@(posedge clk) disable iff (rst_i) wb_rd_addr == exp_rd_addr)
        else begin
            $display("CHECK FAILED wb_rd_addr_o got %h expected %h",
                     $sampled(wb_rd_addr), $sampled(exp_rd_addr));
            err_count++;
        end
    a_wb_data: assert property (@(posedge clk) disable iff (rst_i) wb_rd_data == exp_rd_data)
        else begin
            $display("CHECK FAILED wb_rd_data_o got %h expected %h",
                     $sampled(wb_rd_data), $sampled(exp_rd_data));
            err_count++;
        end
    a_wb_pc: assert property (@(posedge clk) disable iff (rst_i) wb_pc == exp_pc)
        else begin
            $display("CHECK FAILED wb_pc_o got %h expected %h",
                     $sampled(wb_pc), $sampled(exp_pc));
            err_count++;
        end
    a_wb_inst: assert property (@(posedge clk) disable iff (rst_i) wb_inst == exp_inst)
        else begin
            $display("CHECK FAILED wb_inst_o got %h expected %h",
                     $sampled(wb_inst), $sampled(exp_inst));
            err_count++;
        end
    // non-memory instructions never stall
    a_no_stall: assert property (@(posedge clk) disable iff (rst_i)
        (inst_type_i[1:0] == 2'b00) |-> !stall)
        else begin
            $display("CHECK FAILED stall_o got %h expected %h", $sampled(stall), 1'b0);
            err_count++;
        end

    function automatic int size_bytes(input logic [2:0] sel);
        return 1 << sel[1:0];
    endfunction

    function automatic logic [`XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [`XLEN-1:0] read_model(input logic [`ADDR_W-1:0] addr);
        return ref_mem.exists(addr >> 3) ? ref_mem[addr >> 3] : '0;
    endfunction

    // shift the lane down to bit 0, then trim and extend
    function automatic logic [`XLEN-1:0] load_value(input logic [`XLEN-1:0] dw,
                                                    input logic [2:0] off,
                                                    input logic [2:0] sel);
        logic [`XLEN-1:0] val;
        logic [`XLEN-1:0] keep;
        int               bits;
        bits = 8 * size_bytes(sel);
        val  = dw >> (8 * off);
        if (bits == `XLEN) begin
            return val;
        end
        keep = (64'd1 << bits) - 64'd1;
        val  = val & keep;
        if (!sel[2] && val[bits-1]) begin
            val = val | ~keep;
        end
        return val;
    endfunction

    function automatic logic [`XLEN-1:0] store_merge(input logic [`XLEN-1:0] old,
                                                     input logic [`XLEN-1:0] val,
                                                     input logic [2:0] off,
                                                     input logic [2:0] sel);
        logic [`XLEN-1:0] res;
        int               i;
        res = old;
        for (i = 0; i < size_bytes(sel); i++) begin
            res[8 * (off + i) +: 8] = val[8 * i +: 8];
        end
        return res;
    endfunction

    // present one instruction at this edge, hold it through the stall,
    // return on the edge where writeback loads it
    task automatic issue(input logic [7:0] typ, input logic [2:0] sel,
                         input logic [`ADDR_W-1:0] addr, input logic [`XLEN-1:0] op2,
                         input logic ena, input logic [`XLEN-1:0] data);
        logic [`REG_ADDR_W-1:0] rd;
        logic [`INST_W-1:0]     ins;
        int                     stalls;
        int                     exp_stalls;
        rd         = 5'($random(seed));
        ins        = $random(seed);
        stalls     = 0;
        exp_stalls = (typ[1:0] != 2'b00) ? `DRAM_LATENCY : 0;
        inst_type_i <= typ;
        ls_sel_i    <= lsu_op_pkg::ls_sel_e'(sel);
        ls_addr_i   <= addr;
        op2_i       <= op2;
        rd_ena_i    <= ena;
        rd_addr_i   <= rd;
        pc_i        <= next_pc;
        inst_i      <= ins;
        @(negedge clk);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        exp_rd_ena  <= ena;
        exp_rd_addr <= rd;
        exp_rd_data <= data;
        exp_pc      <= next_pc;
        exp_inst    <= ins;
        next_pc = next_pc + 64'd4;
        issued++;
        assert (stalls == exp_stalls) else begin
            $display("stall_o stayed high for %0d cycles instead of %0d at pc %h",
                     stalls, exp_stalls, pc_i);
            err_count++;
        end
    endtask

    task automatic do_store(input logic [`ADDR_W-1:0] addr, input logic [2:0] sel,
                            input logic [`XLEN-1:0] val);
        logic [`XLEN-1:0] old;
        old = read_model(addr);
        issue(8'(1) << lsu_op_pkg::INST_STORE_BIT, sel, addr, val, 1'b0, '0);
        ref_mem[addr >> 3] = store_merge(old, val, addr[2:0], sel);
    endtask

    task automatic do_load(input logic [`ADDR_W-1:0] addr, input logic [2:0] sel);
        logic [`XLEN-1:0] expected;
        expected = load_value(read_model(addr), addr[2:0], sel);
        issue(8'(1) << lsu_op_pkg::INST_LOAD_BIT, sel, addr, rand64(), 1'b1, expected);
    endtask

    // other type bits may be set, only the two memory bits must be clear
    task automatic do_alu();
        issue(8'($random(seed)) & 8'hfc, 3'd0, WIN_BASE, rand64(), 1'b1, '0);
    endtask

    task automatic report_test(input int num, input string name, input int start);
        $display("test %0d %-12s done, %0d errors", num, name, err_count - start);
    endtask

    initial begin
        int               err_start;
        int               i;
        int               s;
        int               off;
        logic [31:0]      r;
        logic [2:0]       sel;
        logic [`ADDR_W-1:0] addr;
        rst_i       = 1'b1;
        inst_type_i = '0;
        rd_ena_i    = 1'b0;
        op2_i       = '0;
        rd_addr_i   = '0;
        pc_i        = '0;
        inst_i      = '0;
        ls_addr_i   = '0;
        ls_sel_i    = lsu_op_pkg::LS_LB;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        err_start = err_count;
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!stall && !wb_rd_ena && wb_rd_addr == '0 && wb_rd_data == '0
                && wb_pc == '0 && wb_inst == '0) else begin
            $display("stall or writeback not clear after reset");
            err_count++;
        end
        @(posedge clk);
        report_test(1, "reset", err_start);

        // fill the window so every later load has known data
        err_start = err_count;
        for (i = 0; i < 8; i++) begin
            do_store(WIN_BASE + 64'(8 * i), 3'd3, rand64());
        end
        for (s = 0; s < 4; s++) begin
            for (off = 0; off < 8; off += size_bytes(3'(s))) begin
                addr = WIN_BASE + 64'(8 * s);
                do_store(addr + 64'(off), 3'(s), rand64());
                do_load(addr, 3'd3);
            end
        end
        report_test(2, "store merge", err_start);

        err_start = err_count;
        for (s = 0; s < 7; s++) begin
            for (off = 0; off < 8; off += size_bytes(3'(s))) begin
                do_load(WIN_BASE + 64'(8 * s + off), 3'(s));
            end
        end
        report_test(3, "load extend", err_start);

        err_start = err_count;
        repeat (4) do_alu();
        report_test(4, "non-memory", err_start);

        // back-to-back mix around the stall edges
        err_start = err_count;
        do_alu();
        do_load(WIN_BASE + 64'd48, 3'd3);
        do_store(WIN_BASE + 64'd48, 3'd3, rand64());
        do_alu();
        do_load(WIN_BASE + 64'd53, 3'd0);
        do_store(WIN_BASE + 64'd53, 3'd0, rand64());
        report_test(5, "stall timing", err_start);

        err_start = err_count;
        repeat (200) begin
            r    = $random(seed);
            addr = WIN_BASE + 64'(8 * r[12:10]);
            if (r[1:0] == 2'd0) begin
                do_alu();
            end else if (r[1:0] == 2'd1) begin
                sel = {1'b0, r[4:3]};
                do_store(addr + 64'(r[9:7] & 3'(~(size_bytes(sel) - 1))), sel, rand64());
            end else begin
                sel = (r[6:4] == 3'd7) ? 3'd3 : r[6:4];
                do_load(addr + 64'(r[9:7] & 3'(~(size_bytes(sel) - 1))), sel);
            end
        end
        report_test(6, "random mix", err_start);

        do_alu();
        repeat (3) @(posedge clk);
        $display("summary: 6 tests, %0d instructions, %0d errors", issued, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
source/lsu_op_pkg.sv
source/dbus_pkg.sv
source/mem_stage.sv
source/data_ram.sv
source/mem_wb_reg.sv
source/mem_subsys_top.sv
bench/tb_mem_subsys.sv

//--- Makefile
# Verilator build, run and lint for the memory subsystem testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_subsys
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides the result, a missing pass line also counts as failure
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "run reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
